/* source/vid_pkg.sv */
`default_nettype none

package vid_pkg;

    // ------------------------------------------------------------
    // fixed raster, order is active / front porch / sync / back porch
    // ------------------------------------------------------------
    localparam int H_ACTIVE = 16;                   // pixels per line
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 2;
    localparam int H_BP     = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 24 cycles

    localparam int V_ACTIVE = 4;                    // lines per frame
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BP     = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 8 lines

    localparam int FIFO_DEPTH = 32;                 // stands in for the frame buffer
    localparam int FIFO_AW    = 5;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------
    typedef logic [7:0]         cam_byte_t;
    typedef logic [7:0]         chan8_t;
    typedef logic [4:0]         hcount_t;
    typedef logic [2:0]         vcount_t;
    typedef logic [FIFO_AW-1:0] fifo_addr_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef struct packed {
        chan8_t red;
        chan8_t green;
        chan8_t blue;
    } rgb888_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } sync_t;

endpackage

`default_nettype wire

/* source/pixel_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_packer
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cam_href,
    input  vid_pkg::cam_byte_t  cam_data,
    output logic                pix_valid,
    input  logic                pix_ready,
    output vid_pkg::rgb565_t    pix_data,
    output logic                overflow
);

    logic               phase;      // 1 while the high byte is stored
    vid_pkg::cam_byte_t hi_byte;
    logic               pair_done;

    assign pair_done = cam_href && phase;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase     <= 1'b0;
            pix_valid <= 1'b0;
            overflow  <= 1'b0;
        end
        else
        begin
            if (pair_done)
            begin
                pix_valid <= 1'b1;
                if (pix_valid && !pix_ready)
                    overflow <= 1'b1;   // held pixel gets replaced
            end
            else if (pix_valid && pix_ready)
                pix_valid <= 1'b0;

            // href low restarts the pair, odd byte is dropped
            phase <= cam_href && !phase;
        end
    end

    // payload
    always_ff @(posedge clk)
    begin
        if (cam_href && !phase)
            hi_byte <= cam_data;                    // first byte is the high half
        if (pair_done)
            pix_data <= vid_pkg::rgb565_t'({hi_byte, cam_data});
    end

endmodule

`default_nettype wire

/* source/pixel_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_fifo
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  vid_pkg::rgb565_t    in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output vid_pkg::rgb565_t    out_data
);

    vid_pkg::rgb565_t           mem [vid_pkg::FIFO_DEPTH];
    vid_pkg::fifo_addr_t        wr_ptr;
    vid_pkg::fifo_addr_t        rd_ptr;
    logic [vid_pkg::FIFO_AW:0]  count;      // one bit wider than the pointers
    logic                       push;
    logic                       pop;

    assign in_ready  = count != (vid_pkg::FIFO_AW + 1)'(vid_pkg::FIFO_DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];         // head entry, read is asynchronous

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + vid_pkg::fifo_addr_t'(1);   // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + vid_pkg::fifo_addr_t'(1);

            case ({push, pop})
                2'b10:   count <= count + (vid_pkg::FIFO_AW + 1)'(1);
                2'b01:   count <= count - (vid_pkg::FIFO_AW + 1)'(1);
                default: count <= count;    // idle or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

/* source/video_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing
(
    input  logic            clk,
    input  logic            rst_n,
    output vid_pkg::sync_t  pos
);

    vid_pkg::hcount_t h_cnt;
    vid_pkg::vcount_t v_cnt;
    logic             line_end;
    logic             frame_end;

    assign line_end  = h_cnt == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1);
    assign frame_end = v_cnt == vid_pkg::vcount_t'(vid_pkg::V_TOTAL - 1);

    // ------------------------------------------------------------
    // free running counters
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (line_end)
        begin
            h_cnt <= '0;
            if (frame_end)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + vid_pkg::vcount_t'(1);
        end
        else
            h_cnt <= h_cnt + vid_pkg::hcount_t'(1);
    end

    // ------------------------------------------------------------
    // decode, positive polarity
    // ------------------------------------------------------------
    always_comb
    begin
        pos.hs = (h_cnt >= vid_pkg::hcount_t'(vid_pkg::H_ACTIVE + vid_pkg::H_FP))
              && (h_cnt <  vid_pkg::hcount_t'(vid_pkg::H_ACTIVE + vid_pkg::H_FP
                                              + vid_pkg::H_SYNC));
        // whole sync line
        pos.vs = (v_cnt >= vid_pkg::vcount_t'(vid_pkg::V_ACTIVE + vid_pkg::V_FP))
              && (v_cnt <  vid_pkg::vcount_t'(vid_pkg::V_ACTIVE + vid_pkg::V_FP
                                              + vid_pkg::V_SYNC));
        pos.de = (h_cnt < vid_pkg::hcount_t'(vid_pkg::H_ACTIVE))
              && (v_cnt < vid_pkg::vcount_t'(vid_pkg::V_ACTIVE));
    end

endmodule

`default_nettype wire

/* source/pixel_output.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_output
(
    input  logic                clk,
    input  logic                rst_n,
    input  vid_pkg::sync_t      pos,
    input  logic                pix_valid,
    output logic                pix_ready,
    input  vid_pkg::rgb565_t    pix_data,
    output logic                vid_hs,
    output logic                vid_vs,
    output logic                vid_de,
    output vid_pkg::rgb888_t    vid_rgb,
    output logic                underflow
);

    vid_pkg::rgb888_t wide;

    assign pix_ready = pos.de;      // one pop per active position

    // zero padding of the low bits
    assign wide.red   = {pix_data.red,   3'b000};
    assign wide.green = {pix_data.green, 2'b00};
    assign wide.blue  = {pix_data.blue,  3'b000};

    // ------------------------------------------------------------
    // display registers, one cycle behind pos
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vid_hs    <= 1'b0;
            vid_vs    <= 1'b0;
            vid_de    <= 1'b0;
            vid_rgb   <= '0;
            underflow <= 1'b0;
        end
        else
        begin
            vid_hs <= pos.hs;
            vid_vs <= pos.vs;
            vid_de <= pos.de;

            if (pos.de && pix_valid)
                vid_rgb <= wide;
            else
                vid_rgb <= '0;          // blanking or empty FIFO

            if (pos.de && !pix_valid)
                underflow <= 1'b1;      // sticky until reset
        end
    end

endmodule

`default_nettype wire

/* source/vid_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vid_bridge_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cam_href,
    input  vid_pkg::cam_byte_t  cam_data,
    output logic                vid_hs,
    output logic                vid_vs,
    output logic                vid_de,
    output vid_pkg::rgb888_t    vid_rgb,
    output logic                overflow,
    output logic                underflow
);

    // packer to FIFO
    logic               pix_valid;
    logic               pix_ready;
    vid_pkg::rgb565_t   pix_data;

    // FIFO to output stage
    logic               out_valid;
    logic               out_ready;
    vid_pkg::rgb565_t   out_data;

    vid_pkg::sync_t     pos;        // raster position

    pixel_packer u_pixel_packer
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .overflow  (overflow)
    );

    pixel_fifo u_pixel_fifo
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .in_data   (pix_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    video_timing u_video_timing
    (
        .clk   (clk),
        .rst_n (rst_n),
        .pos   (pos)
    );

    pixel_output u_pixel_output
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .pos       (pos),
        .pix_valid (out_valid),
        .pix_ready (out_ready),
        .pix_data  (out_data),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_rgb   (vid_rgb),
        .underflow (underflow)
    );

endmodule

`default_nettype wire

/* bench/vid_bridge_props.sv */
`timescale 1ns/100ps
`default_nettype none

module vid_bridge_props
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vid_hs,
    input  logic                vid_vs,
    input  logic                vid_de,
    input  logic                pix_valid,
    input  logic                pix_ready,
    input  vid_pkg::rgb565_t    pix_data,
    input  logic                out_valid,
    input  logic                out_ready,
    input  vid_pkg::rgb565_t    out_data,
    input  logic                overflow,
    input  logic                underflow
);

    // ------------------------------------------------------------
    // display syncs
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n) vid_de |-> !(vid_hs || vid_vs))
        else $error("vid_de high during a sync interval");

    // held pixel may only change when it is replaced on overflow
    assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> ($stable(pix_data) || overflow))
        else $error("packer pixel changed while pending");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("FIFO head changed while pending");

    // sticky flags
    assert property (@(posedge clk) disable iff (!rst_n) !$fell(overflow))
        else $error("overflow fell without reset");
    assert property (@(posedge clk) disable iff (!rst_n) !$fell(underflow))
        else $error("underflow fell without reset");

endmodule

`default_nettype wire

/* bench/vid_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vid_bridge_tb;

    logic               clk;
    logic               rst_n;
    logic               cam_href;
    vid_pkg::cam_byte_t cam_data;
    logic               vid_hs;
    logic               vid_vs;
    logic               vid_de;
    vid_pkg::rgb888_t   vid_rgb;
    logic               overflow;
    logic               underflow;

    vid_pkg::rgb565_t   ref_q [$];          // pixels sent, oldest first
    vid_pkg::sync_t     exp_sync;
    vid_pkg::hcount_t   h_ref;
    vid_pkg::vcount_t   v_ref;
    logic [31:0]        lfsr_state;
    int                 mode;               // 0 idle camera, 1 stream, 2 skip rgb
    int                 rgb_errs;
    int                 sync_errs;
    int                 flag_errs;
    int                 count_errs;

    vid_bridge_top u_vid_bridge_top (.*);

    bind vid_bridge_top vid_bridge_props u_props (.*);

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic vid_pkg::rgb888_t widen(vid_pkg::rgb565_t p);
        logic [15:0] b;
        b = p;
        return vid_pkg::rgb888_t'({b[15:11], 3'b000, b[10:5], 2'b00, b[4:0], 3'b000});
    endfunction

    function automatic vid_pkg::sync_t raster_decode(int h, int v);
        vid_pkg::sync_t s;
        s.hs = h >= vid_pkg::H_ACTIVE + vid_pkg::H_FP
            && h <  vid_pkg::H_ACTIVE + vid_pkg::H_FP + vid_pkg::H_SYNC;
        s.vs = v == vid_pkg::V_ACTIVE + vid_pkg::V_FP;
        s.de = h < vid_pkg::H_ACTIVE && v < vid_pkg::V_ACTIVE;
        return s;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_rgb(input string name, input vid_pkg::rgb888_t exp,
                             input vid_pkg::rgb888_t act);
        if (exp !== act)
        begin
            rgb_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_sync(input string name, input vid_pkg::sync_t exp,
                              input vid_pkg::sync_t act);
        if (exp !== act)
        begin
            sync_errs++;
            $display("[FAIL] %s expected %b actual %b at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            flag_errs++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            count_errs++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // bench raster, one cycle ahead of the display outputs
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_ref    <= '0;
            v_ref    <= '0;
            exp_sync <= '0;
        end
        else
        begin
            exp_sync <= raster_decode(int'(h_ref), int'(v_ref));
            h_ref    <= (h_ref == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1))
                        ? '0 : h_ref + vid_pkg::hcount_t'(1);
            if (h_ref == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1))
                v_ref <= (v_ref == vid_pkg::vcount_t'(vid_pkg::V_TOTAL - 1))
                         ? '0 : v_ref + vid_pkg::vcount_t'(1);
        end
    end

    // compare process, reads the values of the previous edge
    always @(posedge clk)
    begin : compare_proc
        vid_pkg::rgb565_t p;
        if (rst_n)
        begin
            check_sync("raster", exp_sync, vid_pkg::sync_t'({vid_hs, vid_vs, vid_de}));
            if (!vid_de)
                check_rgb("blanking", '0, vid_rgb);
            else if (mode == 1 && ref_q.size() > 0)
            begin
                p = ref_q.pop_front();
                check_rgb("pixel", widen(p), vid_rgb);
            end
            else if (mode != 2)
                check_rgb("empty position", '0, vid_rgb);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic apply_reset();
        rst_n    = 1'b0;
        cam_href = 1'b0;
        cam_data = '0;
        ref_q.delete();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic send_byte(input vid_pkg::cam_byte_t b);
        @(negedge clk);
        cam_href = 1'b1;
        cam_data = b;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        cam_href = 1'b0;
        cam_data = '0;
    endtask

    task automatic send_pixel(input vid_pkg::rgb565_t p);
        send_byte(p[15:8]);                 // high byte first
        send_byte(p[7:0]);
        if (mode == 1)
            ref_q.push_back(p);
    endtask

    task automatic wait_active(input int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n)
        begin
            @(negedge clk);
            if (vid_de)
                seen++;
            guard++;
            if (guard > 2000)
                timed_out("active positions");
        end
    endtask

    // keeps the camera ahead of the display, below FIFO capacity
    task automatic stream_pixels(input int n);
        logic [31:0] r;
        int          idles;
        idles = 0;
        for (int i = 0; i < n; )
        begin
            if (ref_q.size() >= 28)
            begin
                idle_cycle();
                idles++;
                if (idles > 400)
                    timed_out("FIFO drain during streaming");
            end
            else
            begin
                idles = 0;
                take_bits(2, r);
                if (r[1:0] == 2'd0 && ref_q.size() > 20)
                    idle_cycle();
                else if (r[1:0] == 2'd1 && ref_q.size() > 20)
                begin
                    take_bits(8, r);
                    send_byte(r[7:0]);      // lone byte, dropped by the packer
                    idle_cycle();
                end
                take_bits(16, r);
                send_pixel(r[15:0]);
                i++;
            end
        end
        idle_cycle();
    endtask

    task automatic measure_frame();
        int   guard;
        int   de_n;
        int   hs_n;
        int   hs_rise;
        int   vs_n;
        logic hs_prev;
        guard = 0;
        // display shows the first position of a frame after the next edge
        while (h_ref != '0 || v_ref != '0)
        begin
            @(negedge clk);
            guard++;
            if (guard > 400)
                timed_out("start of a frame");
        end
        de_n    = 0;
        hs_n    = 0;
        hs_rise = 0;
        vs_n    = 0;
        hs_prev = vid_hs;
        repeat (vid_pkg::H_TOTAL * vid_pkg::V_TOTAL)
        begin
            @(negedge clk);
            de_n    += int'(vid_de);
            hs_n    += int'(vid_hs);
            vs_n    += int'(vid_vs);
            hs_rise += int'(vid_hs && !hs_prev);
            hs_prev = vid_hs;
        end
        check_count("de per frame", 64, de_n);
        check_count("hs pulses per frame", 8, hs_rise);
        check_count("hs cycles per frame", 16, hs_n);
        check_count("vs cycles per frame", 24, vs_n);
    endtask

    initial
    begin
        int guard;
        clk        = 1'b0;
        lfsr_state = 32'hf78e;
        mode       = 0;
        rgb_errs   = 0;
        sync_errs  = 0;
        flag_errs  = 0;
        count_errs = 0;
        apply_reset();
        check_flag("overflow after reset", 1'b0, overflow);
        check_flag("underflow after reset", 1'b0, underflow);

        // first frame finds an empty FIFO
        wait_active(64);
        check_flag("underflow first frame", 1'b1, underflow);

        mode = 1;
        stream_pixels(160);
        guard = 0;
        while (ref_q.size() > 0)
        begin
            @(negedge clk);
            guard++;
            if (guard > 2000)
                timed_out("display of the sent pixels");
        end
        check_flag("overflow after stream", 1'b0, overflow);

        // camera stopped, display keeps running black
        measure_frame();
        check_flag("underflow after stop", 1'b1, underflow);

        // burst during vertical blanking
        apply_reset();
        mode = 2;
        wait_active(64);
        repeat (40)
            send_pixel(16'h5a5a);
        idle_cycle();
        check_flag("overflow after burst", 1'b1, overflow);
        wait_active(64);
        check_flag("overflow held", 1'b1, overflow);

        $display("errors: rgb %0d, sync %0d, flag %0d, count %0d",
                 rgb_errs, sync_errs, flag_errs, count_errs);
        if (rgb_errs + sync_errs + flag_errs + count_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vid_bridge.f */
source/vid_pkg.sv
source/pixel_packer.sv
source/pixel_fifo.sv
source/video_timing.sv
source/pixel_output.sv
source/vid_bridge_top.sv
bench/vid_bridge_props.sv
bench/vid_bridge_tb.sv

/* Makefile */
TOP = vid_bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vid_bridge.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vid_bridge.f -o sim_exe
	./obj_dir/sim_exe > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
